// ==== Makefile ====
SOURCES := $(shell cat all.f)

obj_dir/Vtb_fp_add: all.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fp_add -f all.f -o Vtb_fp_add

run: obj_dir/Vtb_fp_add
	./obj_dir/Vtb_fp_add +verilator+error+limit+100 | tee sim.log
	grep -q -F '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== all.f ====
fp_pkg.sv
fp_add_align.sv
fp_normalize.sv
fp_round.sv
fp_axil_regs.sv
fp_add_top.sv
fp_add_sva.sv
tb_fp_add.sv

// ==== fp_add_align.sv ====
`timescale 1ns/1ps

module fp_add_align (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic                 sub,
    input  logic [31:0]          op_a,
    input  logic [31:0]          op_b,
    output fp_pkg::fp_norm_req_t norm_req,
    output logic                 norm_valid
);

    logic                            sign_a, sign_b, sign_big;
    logic [fp_pkg::EXPO_WIDTH-1:0]   expo_a, expo_b, expo_big, expo_small, expo_diff;
    logic [fp_pkg::FRAC_WIDTH-1:0]   frac_a, frac_b, frac_big, frac_small;
    logic                            nan_a, nan_b, inf_a, inf_b;
    logic                            swap, eff_sub, sticky, lead_found;
    logic [fp_pkg::SUM_WIDTH-2:0]    sig_big, sig_small, small_shifted, lost_mask, sig_aligned;
    logic [fp_pkg::SUM_WIDTH-1:0]    sum;
    fp_pkg::fp_shift_amt_t           lzc;
    fp_pkg::fp_norm_req_t            req_next;

    // Unpack, subnormals read as zero
    assign sign_a = op_a[31];
    assign sign_b = op_b[31] ^ sub;
    assign expo_a = op_a[30:23];
    assign expo_b = op_b[30:23];
    assign frac_a = (expo_a == '0) ? '0 : op_a[22:0];
    assign frac_b = (expo_b == '0) ? '0 : op_b[22:0];

    assign nan_a = (&expo_a) & (|op_a[22:0]);
    assign nan_b = (&expo_b) & (|op_b[22:0]);
    assign inf_a = (&expo_a) & ~(|op_a[22:0]);
    assign inf_b = (&expo_b) & ~(|op_b[22:0]);

    // Larger magnitude goes first so the difference never goes negative
    assign swap = {expo_b, frac_b} > {expo_a, frac_a};
    assign {sign_big, expo_big, frac_big} = swap ? {sign_b, expo_b, frac_b}
                                                 : {sign_a, expo_a, frac_a};
    assign {expo_small, frac_small} = swap ? {expo_a, frac_a} : {expo_b, frac_b};

    assign sig_big = {|expo_big, frac_big, 3'b000};
    assign sig_small = {|expo_small, frac_small, 3'b000};
    assign expo_diff = expo_big - expo_small;

    // Alignment shift, everything shifted out collapses into the sticky bit
    assign small_shifted = sig_small >> expo_diff;
    assign lost_mask = ~({(fp_pkg::SUM_WIDTH-1){1'b1}} << expo_diff);
    assign sticky = |(sig_small & lost_mask);
    assign sig_aligned = {small_shifted[fp_pkg::SUM_WIDTH-2:1], small_shifted[0] | sticky};

    assign eff_sub = sign_a ^ sign_b;
    assign sum = eff_sub ? {1'b0, sig_big} - {1'b0, sig_aligned}
                         : {1'b0, sig_big} + {1'b0, sig_aligned};

    // Leading zeros below the carry position
    always_comb begin
        lzc = '0;
        lead_found = 1'b0;
        for (int i = fp_pkg::SUM_WIDTH - 2; i >= 0; i--) begin
            if (sum[i]) begin
                lead_found = 1'b1;
            end else if (!lead_found) begin
                lzc = lzc + 1'b1;
            end
        end
    end

    always_comb begin
        req_next = '0;
        req_next.num.sign = sign_big;
        req_next.num.expo = expo_big;
        {req_next.num.frac_carry_bit, req_next.num.hidden_bit,
         req_next.num.frac, req_next.num.grs} = sum;
        req_next.left_shift_amt = lzc;
        req_next.right_shift = sum[fp_pkg::SUM_WIDTH-1];

        if (nan_a || nan_b || (inf_a && inf_b && eff_sub)) begin
            req_next.special = 1'b1;
            req_next.special_value = fp_pkg::CANON_QNAN;
        end else if (inf_a) begin
            req_next.special = 1'b1;
            req_next.special_value = {sign_a, fp_pkg::INF_MAG};
        end else if (inf_b) begin
            req_next.special = 1'b1;
            req_next.special_value = {sign_b, fp_pkg::INF_MAG};
        end else if (sum == '0) begin
            // Exact zero is -0 only when both inputs are -0
            req_next.special = 1'b1;
            req_next.special_value = {sign_a & sign_b, 31'b0};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            norm_req <= '0;
            norm_valid <= 1'b0;
        end else begin
            norm_valid <= start;
            if (start) begin
                norm_req <= req_next;
            end
        end
    end

endmodule

// ==== fp_add_sva.sv ====
`timescale 1ns/1ps

module fp_add_sva (
    input logic              clk,
    input logic              rst_n,
    input fp_pkg::axil_req_t axil_req,
    input fp_pkg::axil_rsp_t axil_rsp,
    input logic              start,
    input logic              busy,
    input logic              done
);

    int fail_count = 0;

    // Write response channel
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else begin
        $error("bvalid dropped before bready");
        fail_count++;
    end

    a_bresp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> $stable(axil_rsp.bresp))
    else begin
        $error("bresp changed while bvalid was pending");
        fail_count++;
    end

    // Read response channel
    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
    else begin
        $error("rvalid dropped before rready");
        fail_count++;
    end

    a_rresp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> $stable(axil_rsp.rresp))
    else begin
        $error("rresp changed while rvalid was pending");
        fail_count++;
    end

    a_busy_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(busy && done))
    else begin
        $error("busy and done high together");
        fail_count++;
    end

    // Two edges from the start cycle to done
    a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        start |=> !done ##1 done)
    else begin
        $error("done did not rise two edges after start");
        fail_count++;
    end

endmodule

bind fp_axil_regs fp_add_sva u_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .start    (start),
    .busy     (busy),
    .done     (done)
);

// ==== fp_add_top.sv ====
`timescale 1ns/1ps

module fp_add_top (
    input  logic              clk,
    input  logic              rst_n,
    input  fp_pkg::axil_req_t axil_req,
    output fp_pkg::axil_rsp_t axil_rsp
);

    logic                 start, sub;
    logic [31:0]          op_a, op_b;
    fp_pkg::fp_norm_req_t norm_req;
    logic                 norm_valid;
    fp_pkg::fp_unpacked_t norm_out;
    logic                 overflow_before_rounding;
    fp_pkg::fp_result_t   result;
    logic                 result_valid;

    fp_axil_regs u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .start        (start),
        .sub          (sub),
        .op_a         (op_a),
        .op_b         (op_b),
        .result       (result),
        .result_valid (result_valid)
    );

    // Align and add, registered request
    fp_add_align u_align (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .sub        (sub),
        .op_a       (op_a),
        .op_b       (op_b),
        .norm_req   (norm_req),
        .norm_valid (norm_valid)
    );

    fp_normalize u_normalize (
        .norm_req                 (norm_req),
        .norm_out                 (norm_out),
        .overflow_before_rounding (overflow_before_rounding)
    );

    fp_round u_round (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .norm_valid               (norm_valid),
        .norm_req                 (norm_req),
        .norm_out                 (norm_out),
        .overflow_before_rounding (overflow_before_rounding),
        .result                   (result),
        .result_valid             (result_valid)
    );

endmodule

// ==== fp_axil_regs.sv ====
`timescale 1ns/1ps

module fp_axil_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  fp_pkg::axil_req_t  axil_req,
    output fp_pkg::axil_rsp_t  axil_rsp,
    output logic               start,
    output logic               sub,
    output logic [31:0]        op_a,
    output logic [31:0]        op_b,
    input  fp_pkg::fp_result_t result,
    input  logic               result_valid
);

    logic        awready, arready, bvalid, rvalid;
    logic [1:0]  bresp, rresp, wr_resp, rd_resp;
    logic [31:0] rdata, rd_word, ctrl_word, status_word;
    logic        wr_fire, rd_fire, wr_ctrl, start_req, status_rd;
    logic        ctrl_sub, busy_q, done_q, busy, done;

    assign wr_fire = awready & axil_req.awvalid & axil_req.wvalid;
    assign rd_fire = arready & axil_req.arvalid;
    assign wr_ctrl = wr_fire && (axil_req.awaddr == fp_pkg::REG_CTRL);
    assign start_req = wr_ctrl & axil_req.wdata[fp_pkg::CTRL_START_BIT];
    assign status_rd = rd_fire && (axil_req.araddr == fp_pkg::REG_STATUS);

    // The result register in fp_round updates on the same edge that ends busy
    assign busy = busy_q & ~result_valid;
    assign done = done_q | result_valid;

    assign start = start_req & ~busy;
    assign sub = wr_ctrl ? axil_req.wdata[fp_pkg::CTRL_SUB_BIT] : ctrl_sub;

    always_comb begin
        case (axil_req.awaddr)
            fp_pkg::REG_OP_A, fp_pkg::REG_OP_B: wr_resp = fp_pkg::RESP_OKAY;
            fp_pkg::REG_CTRL:
                wr_resp = (axil_req.wdata[fp_pkg::CTRL_START_BIT] && busy) ?
                          fp_pkg::RESP_SLVERR : fp_pkg::RESP_OKAY;
            // STATUS and RESULT are read only
            default: wr_resp = fp_pkg::RESP_SLVERR;
        endcase
    end

    always_comb begin
        ctrl_word = '0;
        ctrl_word[fp_pkg::CTRL_SUB_BIT] = ctrl_sub;
        status_word = '0;
        status_word[fp_pkg::STAT_BUSY_BIT] = busy;
        status_word[fp_pkg::STAT_DONE_BIT] = done;
        status_word[fp_pkg::STAT_OVF_BIT] = result.overflow;
        status_word[fp_pkg::STAT_INEXACT_BIT] = result.inexact;
        rd_resp = fp_pkg::RESP_OKAY;
        case (axil_req.araddr)
            fp_pkg::REG_OP_A:   rd_word = op_a;
            fp_pkg::REG_OP_B:   rd_word = op_b;
            fp_pkg::REG_CTRL:   rd_word = ctrl_word;
            fp_pkg::REG_STATUS: rd_word = status_word;
            fp_pkg::REG_RESULT: rd_word = result.value;
            default: begin
                rd_word = '0;
                rd_resp = fp_pkg::RESP_SLVERR;
            end
        endcase
    end

    // Handshakes, one transaction per channel until its response is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            arready <= 1'b0;
            bvalid <= 1'b0;
            bresp <= '0;
            rvalid <= 1'b0;
            rresp <= '0;
            rdata <= '0;
        end else begin
            awready <= axil_req.awvalid & axil_req.wvalid & ~awready & ~bvalid;
            arready <= axil_req.arvalid & ~arready & ~rvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp <= wr_resp;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
                rresp <= rd_resp;
                rdata <= rd_word;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_a <= '0;
            op_b <= '0;
            ctrl_sub <= 1'b0;
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            if (wr_fire && axil_req.awaddr == fp_pkg::REG_OP_A) begin
                op_a <= axil_req.wdata;
            end
            if (wr_fire && axil_req.awaddr == fp_pkg::REG_OP_B) begin
                op_b <= axil_req.wdata;
            end
            // A rejected start leaves CTRL untouched
            if (wr_ctrl && !(start_req && busy)) begin
                ctrl_sub <= axil_req.wdata[fp_pkg::CTRL_SUB_BIT];
            end
            if (start) begin
                busy_q <= 1'b1;
            end else if (result_valid) begin
                busy_q <= 1'b0;
            end
            if (start || status_rd) begin
                done_q <= 1'b0;
            end else if (result_valid) begin
                done_q <= 1'b1;
            end
        end
    end

    assign axil_rsp.awready = awready;
    assign axil_rsp.wready = awready;
    assign axil_rsp.bresp = bresp;
    assign axil_rsp.bvalid = bvalid;
    assign axil_rsp.arready = arready;
    assign axil_rsp.rdata = rdata;
    assign axil_rsp.rresp = rresp;
    assign axil_rsp.rvalid = rvalid;

endmodule

// ==== fp_normalize.sv ====
`timescale 1ns/1ps

module fp_normalize (
    input  fp_pkg::fp_norm_req_t norm_req,
    output fp_pkg::fp_unpacked_t norm_out,
    output logic                 overflow_before_rounding
);

    fp_pkg::fp_unpacked_t            num;
    fp_pkg::fp_unpacked_t            norm;
    // Safe bit sits above the carry and stays clear for add and subtract
    logic [fp_pkg::SUM_WIDTH:0]      sig, sig_right, sig_left;
    logic [fp_pkg::EXPO_WIDTH:0]     expo_right, expo_left;
    logic                            expo_lt_shift;
    logic [fp_pkg::EXPO_WIDTH-1:0]   expo_shifted;
    fp_pkg::fp_shift_amt_t           shift_clamped;

    assign num = norm_req.num;
    assign sig = {num.frac_safe_bit, num.frac_carry_bit, num.hidden_bit, num.frac, num.grs};

    // Right shift is one place at most, the dropped bit joins sticky
    assign sig_right = {1'b0, sig[fp_pkg::SUM_WIDTH:2], sig[1] | sig[0]};
    assign expo_right = {num.expo_overflow, num.expo} + (fp_pkg::EXPO_WIDTH+1)'(1);

    // Left shift never takes the exponent below zero
    always_comb begin
        {expo_lt_shift, expo_shifted} = {1'b0, num.expo}
                                        - (fp_pkg::EXPO_WIDTH+1)'(norm_req.left_shift_amt);
        shift_clamped = expo_lt_shift ? fp_pkg::fp_shift_amt_t'(num.expo)
                                      : norm_req.left_shift_amt;
        sig_left = sig << shift_clamped;
        sig_left[0] = sig_left[0] | sig[0];
        expo_left = expo_lt_shift ? '0 : {1'b0, expo_shifted};
    end

    always_comb begin
        norm.sign = num.sign;
        if (norm_req.right_shift) begin
            {norm.expo_overflow, norm.expo} = expo_right;
            {norm.frac_safe_bit, norm.frac_carry_bit, norm.hidden_bit,
             norm.frac, norm.grs} = sig_right;
        end else begin
            {norm.expo_overflow, norm.expo} = expo_left;
            {norm.frac_safe_bit, norm.frac_carry_bit, norm.hidden_bit,
             norm.frac, norm.grs} = sig_left;
        end
    end

    assign norm_out = norm;
    assign overflow_before_rounding = norm.expo_overflow | (&norm.expo);

endmodule

// ==== fp_pkg.sv ====
package fp_pkg;

    localparam int EXPO_WIDTH = 8;
    localparam int FRAC_WIDTH = 23;
    // Carry, hidden, fraction and guard/round/sticky of the significand sum
    localparam int SUM_WIDTH = FRAC_WIDTH + 5;
    localparam int AXIL_ADDR_WIDTH = 5;

    localparam logic [31:0] CANON_QNAN = 32'h7fc0_0000;
    localparam logic [30:0] INF_MAG = 31'h7f80_0000;

    typedef logic [4:0] fp_shift_amt_t;
    typedef logic [2:0] grs_t;

    typedef struct packed {
        logic                  sign;
        logic                  expo_overflow;
        logic [EXPO_WIDTH-1:0] expo;
        logic                  frac_carry_bit;
        logic                  frac_safe_bit;
        logic                  hidden_bit;
        logic [FRAC_WIDTH-1:0] frac;
        grs_t                  grs;
    } fp_unpacked_t;

    typedef struct packed {
        fp_unpacked_t  num;
        fp_shift_amt_t left_shift_amt;
        logic          right_shift;
        logic          special;
        logic [31:0]   special_value;
    } fp_norm_req_t;

    typedef struct packed {
        logic [31:0] value;
        logic        overflow;
        logic        inexact;
    } fp_result_t;

    typedef struct packed {
        logic [AXIL_ADDR_WIDTH-1:0] awaddr;
        logic                       awvalid;
        logic [31:0]                wdata;
        logic                       wvalid;
        logic                       bready;
        logic [AXIL_ADDR_WIDTH-1:0] araddr;
        logic                       arvalid;
        logic                       rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

    // Register map
    localparam logic [AXIL_ADDR_WIDTH-1:0] REG_OP_A   = 5'h00;
    localparam logic [AXIL_ADDR_WIDTH-1:0] REG_OP_B   = 5'h04;
    localparam logic [AXIL_ADDR_WIDTH-1:0] REG_CTRL   = 5'h08;
    localparam logic [AXIL_ADDR_WIDTH-1:0] REG_STATUS = 5'h0C;
    localparam logic [AXIL_ADDR_WIDTH-1:0] REG_RESULT = 5'h10;

    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_SUB_BIT = 1;

    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;
    localparam int STAT_OVF_BIT = 2;
    localparam int STAT_INEXACT_BIT = 3;

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== fp_round.sv ====
`timescale 1ns/1ps

module fp_round (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 norm_valid,
    input  fp_pkg::fp_norm_req_t norm_req,
    input  fp_pkg::fp_unpacked_t norm_out,
    input  logic                 overflow_before_rounding,
    output fp_pkg::fp_result_t   result,
    output logic                 result_valid
);

    logic                          round_up, mant_carry, overflow_after;
    logic [fp_pkg::FRAC_WIDTH-1:0] frac_rounded;
    logic [fp_pkg::EXPO_WIDTH:0]   expo_rounded;
    fp_pkg::fp_result_t            result_next;

    // Nearest even: guard set and anything below it or an odd LSB
    assign round_up = norm_out.grs[2] & (norm_out.grs[1] | norm_out.grs[0] | norm_out.frac[0]);
    assign {mant_carry, frac_rounded} = {1'b0, norm_out.frac}
                                        + (fp_pkg::FRAC_WIDTH+1)'(round_up);
    assign expo_rounded = {norm_out.expo_overflow, norm_out.expo}
                          + (fp_pkg::EXPO_WIDTH+1)'(mant_carry);
    assign overflow_after = expo_rounded[fp_pkg::EXPO_WIDTH]
                            | (&expo_rounded[fp_pkg::EXPO_WIDTH-1:0]);

    always_comb begin
        result_next.overflow = 1'b0;
        result_next.inexact = |norm_out.grs;
        if (norm_req.special) begin
            result_next.value = norm_req.special_value;
            result_next.inexact = 1'b0;
        end else if (overflow_before_rounding || overflow_after) begin
            result_next.value = {norm_out.sign, fp_pkg::INF_MAG};
            result_next.overflow = 1'b1;
        end else if (norm_out.expo == '0) begin
            // Result below the normal range is flushed
            result_next.value = {norm_out.sign, 31'b0};
        end else begin
            result_next.value = {norm_out.sign, expo_rounded[fp_pkg::EXPO_WIDTH-1:0],
                                 frac_rounded};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= norm_valid;
            if (norm_valid) begin
                result <= result_next;
            end
        end
    end

endmodule

// ==== tb_fp_add.sv ====
`timescale 1ns/1ps

module tb_fp_add;

    logic              clk;
    logic              rst_n;
    fp_pkg::axil_req_t axil_req;
    fp_pkg::axil_rsp_t axil_rsp;

    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;
    int          sva_fails = 0;
    logic [31:0] lfsr_state = 32'h845d;

    fp_add_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic int unsigned random_bits(input int n);
        int unsigned r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | int'(lfsr_step());
        end
        return r;
    endfunction

    function automatic real fp32_to_real(input logic [31:0] f);
        logic [10:0] e;
        if (f[30:23] == 8'h00) begin
            return $bitstoreal({f[31], 63'b0});
        end
        e = 11'(f[30:23]) - 11'd127 + 11'd1023;
        return $bitstoreal({f[31], e, f[22:0], 29'b0});
    endfunction

    // Nearest even, flush below the normal range, infinity above it
    function automatic logic [31:0] real_to_fp32(input real r);
        logic [63:0] d;
        logic [23:0] m;
        int          expo;
        d = $realtobits(r);
        if (d[62:52] == 11'd0) begin
            return {d[63], 31'b0};
        end
        expo = int'(d[62:52]) - 1023 + 127;
        if (expo <= 0) begin
            return {d[63], 31'b0};
        end
        m = {1'b0, d[51:29]};
        if (d[28] && ((d[27:0] != 28'd0) || m[0])) begin
            m = m + 24'd1;
        end
        if (m[23]) begin
            expo = expo + 1;
        end
        if (expo >= 255) begin
            return {d[63], 8'hff, 23'b0};
        end
        return {d[63], expo[7:0], m[22:0]};
    endfunction

    // Small integer times a power of two keeps sums exact
    function automatic logic [31:0] random_operand();
        int unsigned mag;
        int unsigned scale;
        logic        neg;
        real         r;
        mag = random_bits(12) | 1;
        scale = random_bits(3);
        neg = random_bits(1) != 0;
        r = real'(mag << scale);
        if (neg) begin
            r = -r;
        end
        return real_to_fp32(r);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, expected);
        end
    endtask

    task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int n;
        @(posedge clk);
        #1;
        axil_req.awaddr = addr;
        axil_req.wdata = data;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid = 1'b1;
        n = 0;
        while (!axil_rsp.awready && n < 100) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (n >= 100) begin
            timeouts++;
            $display("Timeout: slave never raised awready");
        end else begin
            check_value("wready", 32'(axil_rsp.wready), 32'd1);
        end
        // Handshake completes on the edge after awready is seen
        @(posedge clk);
        #1;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid = 1'b0;
        n = 0;
        while (!axil_rsp.bvalid && n < 100) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (n >= 100) begin
            timeouts++;
            $display("Timeout: no write response from the slave");
        end
        resp = axil_rsp.bresp;
        // Hold the response off for a cycle before taking it
        @(posedge clk);
        #1;
        axil_req.bready = 1'b1;
        @(posedge clk);
        #1;
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [4:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        @(posedge clk);
        #1;
        axil_req.araddr = addr;
        axil_req.arvalid = 1'b1;
        n = 0;
        while (!axil_rsp.arready && n < 100) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (n >= 100) begin
            timeouts++;
            $display("Timeout: slave never raised arready");
        end
        @(posedge clk);
        #1;
        axil_req.arvalid = 1'b0;
        n = 0;
        while (!axil_rsp.rvalid && n < 100) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (n >= 100) begin
            timeouts++;
            $display("Timeout: no read data from the slave");
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        // Hold the read data off for a cycle before taking it
        @(posedge clk);
        #1;
        axil_req.rready = 1'b1;
        @(posedge clk);
        #1;
        axil_req.rready = 1'b0;
    endtask

    function automatic logic [31:0] ctrl_word(input logic do_sub);
        logic [31:0] w;
        w = '0;
        w[fp_pkg::CTRL_START_BIT] = 1'b1;
        w[fp_pkg::CTRL_SUB_BIT] = do_sub;
        return w;
    endfunction

    // Load operands, start, poll STATUS until done, then fetch RESULT
    task automatic run_op(input logic [31:0] a, input logic [31:0] b, input logic do_sub,
                          output logic [31:0] value, output logic [31:0] status);
        logic [1:0] resp;
        int         n;
        axil_write(fp_pkg::REG_OP_A, a, resp);
        axil_write(fp_pkg::REG_OP_B, b, resp);
        axil_write(fp_pkg::REG_CTRL, ctrl_word(do_sub), resp);
        check_value("bresp", 32'(resp), 32'(fp_pkg::RESP_OKAY));
        status = '0;
        n = 0;
        while (!status[fp_pkg::STAT_DONE_BIT] && n < 100) begin
            axil_read(fp_pkg::REG_STATUS, status, resp);
            n++;
        end
        if (!status[fp_pkg::STAT_DONE_BIT]) begin
            timeouts++;
            $display("Timeout: operation never reported done");
        end
        axil_read(fp_pkg::REG_RESULT, value, resp);
    endtask

    task automatic check_op(input string name, input logic [31:0] a, input logic [31:0] b,
                            input logic do_sub);
        real         exact;
        logic [31:0] expected, value, status;
        exact = do_sub ? fp32_to_real(a) - fp32_to_real(b) : fp32_to_real(a) + fp32_to_real(b);
        expected = real_to_fp32(exact);
        run_op(a, b, do_sub, value, status);
        check_value({name, ".result"}, value, expected);
        check_value({name, ".overflow"}, 32'(status[fp_pkg::STAT_OVF_BIT]), 32'd0);
        check_value({name, ".inexact"}, 32'(status[fp_pkg::STAT_INEXACT_BIT]),
                    32'(fp32_to_real(expected) != exact));
    endtask

    initial begin
        logic [31:0] value, status, word;
        logic [1:0]  resp, rd_resp;
        logic [31:0] a, b;
        logic        do_sub;

        axil_req = '0;
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Exact results, swap and cancellation
        check_op("add_carry", 32'h40400000, 32'h40a00000, 1'b0);
        check_op("sub_swap", 32'h3f800000, 32'h40400000, 1'b1);
        check_op("sub_cancel", 32'h3fc00000, 32'h3fa00000, 1'b1);
        for (int i = 0; i < 24; i++) begin
            a = random_operand();
            b = random_operand();
            do_sub = random_bits(1) != 0;
            check_op("random", a, b, do_sub);
        end

        // Zero and flush
        check_op("x_minus_x", 32'h40490fdb, 32'h40490fdb, 1'b1);
        run_op(32'h00800001, 32'h00800000, 1'b1, value, status);
        check_value("flush.result", value, 32'h00000000);
        check_op("subnormal_in", 32'h00000005, 32'h3f800000, 1'b0);

        // Ties to even where the last one carries into the exponent
        check_op("tie_even", 32'h3f800000, 32'h33800000, 1'b0);
        check_op("tie_odd", 32'h3f800001, 32'h33800000, 1'b0);
        check_op("tie_carry", 32'h3fffffff, 32'h33800000, 1'b0);

        // Specials
        run_op(32'h7f7fffff, 32'h7f7fffff, 1'b0, value, status);
        check_value("max_plus_max.result", value, 32'h7f800000);
        check_value("max_plus_max.overflow", 32'(status[fp_pkg::STAT_OVF_BIT]), 32'd1);
        run_op(32'h7f800000, 32'h7f800000, 1'b1, value, status);
        check_value("inf_minus_inf.result", value, 32'h7fc00000);
        check_value("inf_minus_inf.overflow", 32'(status[fp_pkg::STAT_OVF_BIT]), 32'd0);
        run_op(32'h7f800000, 32'h3f800000, 1'b0, value, status);
        check_value("inf_plus_one.result", value, 32'h7f800000);
        check_value("inf_plus_one.overflow", 32'(status[fp_pkg::STAT_OVF_BIT]), 32'd0);

        // STATUS read one cycle behind the start lands while busy
        fork
            axil_write(fp_pkg::REG_CTRL, ctrl_word(1'b0), resp);
            begin
                @(posedge clk);
                axil_read(fp_pkg::REG_STATUS, word, rd_resp);
            end
        join
        check_value("status.busy", 32'(word[fp_pkg::STAT_BUSY_BIT]), 32'd1);
        check_value("status.done", 32'(word[fp_pkg::STAT_DONE_BIT]), 32'd0);

        // Done clears once STATUS has been read
        check_op("one_plus_one", 32'h3f800000, 32'h3f800000, 1'b0);
        axil_read(fp_pkg::REG_STATUS, word, resp);
        check_value("status.done_after_read", 32'(word[fp_pkg::STAT_DONE_BIT]), 32'd0);

        // Unmapped and read-only addresses
        axil_read(5'h14, word, resp);
        check_value("rresp", 32'(resp), 32'(fp_pkg::RESP_SLVERR));
        axil_write(fp_pkg::REG_STATUS, 32'h0, resp);
        check_value("bresp", 32'(resp), 32'(fp_pkg::RESP_SLVERR));
        axil_write(5'h18, 32'h0, resp);
        check_value("bresp", 32'(resp), 32'(fp_pkg::RESP_SLVERR));

        repeat (4) @(posedge clk);
        sva_fails = dut.u_regs.u_sva.fail_count;
        $display("checks %0d errors %0d timeouts %0d assertion failures %0d",
                 checks, errors, timeouts, sva_fails);
        if (errors == 0 && timeouts == 0 && sva_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
